//--- Bender.yml
package:
  name: serial_divider

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/div_pkg.sv
      - verilog/div_operand_setup.sv
      - verilog/div_ctrl.sv
      - verilog/div_restoring_core.sv
      - verilog/div_result_fixup.sv
      - verilog/div_top.sv
  - target: test
    include_dirs:
      - verilog
      - tests
    files:
      - tests/div_tb.sv

//--- project.f
+incdir+verilog
+incdir+tests
verilog/div_pkg.sv
verilog/div_operand_setup.sv
verilog/div_ctrl.sv
verilog/div_restoring_core.sv
verilog/div_result_fixup.sv
verilog/div_top.sv
tests/div_tb.sv

//--- tests/div_tb_vectors.svh
// Divider test vectors
// directed cases for quotient and remainder signs, divide by zero,
// signed overflow and unsigned corner values
// columns: operation, opa, opb, expected result

`ifndef DIV_TB_VECTORS_SVH
`define DIV_TB_VECTORS_SVH

typedef struct packed {
  div_op_e              op;
  logic [`DIV_XLEN-1:0] opa;
  logic [`DIV_XLEN-1:0] opb;
  logic [`DIV_XLEN-1:0] exp;
} vec_t;

localparam int NUM_VECTORS = 25;

localparam vec_t VECTORS [NUM_VECTORS] = '{
  '{OP_DIV,  32'hFFFFFFF9, 32'h00000002, 32'hFFFFFFFD}, // -7 / 2
  '{OP_DIV,  32'h00000007, 32'hFFFFFFFE, 32'hFFFFFFFD}, // 7 / -2
  '{OP_DIV,  32'hFFFFFFF9, 32'hFFFFFFFE, 32'h00000003}, // -7 / -2
  '{OP_DIV,  32'h00000007, 32'h00000002, 32'h00000003},
  '{OP_DIVU, 32'hFFFFFFF9, 32'h00000002, 32'h7FFFFFFC},
  '{OP_DIVU, 32'h00000064, 32'h00000007, 32'h0000000E},
  '{OP_DIVU, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000001},
  '{OP_DIVU, 32'h00000005, 32'h80000000, 32'h00000000},
  '{OP_REM,  32'hFFFFFFF9, 32'h00000002, 32'hFFFFFFFF}, // -7 % 2
  '{OP_REM,  32'h00000007, 32'hFFFFFFFE, 32'h00000001}, // 7 % -2
  '{OP_REM,  32'hFFFFFFF9, 32'hFFFFFFFE, 32'hFFFFFFFF},
  '{OP_REM,  32'h00000007, 32'h00000002, 32'h00000001},
  '{OP_REMU, 32'hFFFFFFF9, 32'h00000002, 32'h00000001},
  '{OP_REMU, 32'h00000064, 32'h00000007, 32'h00000002},
  '{OP_REMU, 32'hDEADBEEF, 32'h00000010, 32'h0000000F},
  '{OP_DIV,  32'h12345678, 32'h00000000, 32'hFFFFFFFF}, // divide by zero
  '{OP_DIVU, 32'h00000000, 32'h00000000, 32'hFFFFFFFF},
  '{OP_REM,  32'h87654321, 32'h00000000, 32'h87654321},
  '{OP_REMU, 32'h13579BDF, 32'h00000000, 32'h13579BDF},
  '{OP_DIV,  32'h80000000, 32'hFFFFFFFF, 32'h80000000}, // signed overflow
  '{OP_REM,  32'h80000000, 32'hFFFFFFFF, 32'h00000000},
  '{OP_DIVU, 32'h80000000, 32'hFFFFFFFF, 32'h00000000},
  '{OP_REMU, 32'h80000000, 32'hFFFFFFFF, 32'h80000000},
  '{OP_DIV,  32'h80000000, 32'h00000001, 32'h80000000},
  '{OP_DIV,  32'h80000000, 32'h00000002, 32'hC0000000}
};

`endif

//--- tests/div_tb.sv
// Divider testbench
// directed table, random operands and stalled results against
// reference values from the RISC-V division rules

`timescale 1ns/1ps

`include "div_consts.svh"

module div_tb;

  import div_pkg::*;

  `include "div_tb_vectors.svh"

  localparam int WAIT_LIMIT = 200;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 req_valid_i;
  div_op_e              req_op_i;
  logic [`DIV_XLEN-1:0] opa_i;
  logic [`DIV_XLEN-1:0] opb_i;
  logic                 stall_i;
  logic                 busy_o;
  logic                 res_valid_o;
  logic [`DIV_XLEN-1:0] res_o;
  integer               seed;
  int                   case_idx;

  div_top div_top_i (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic special_case(input div_op_e op, input logic [31:0] a, b);
    logic signed_op;
    signed_op = (op == OP_DIV) || (op == OP_REM);
    special_case = (b == 0) || (signed_op && a == 32'h80000000 && b == 32'hFFFFFFFF);
  endfunction

  // reference value, special rules first
  function automatic logic [31:0] ref_result(input div_op_e op, input logic [31:0] a, b);
    logic is_rem;
    is_rem = (op == OP_REM) || (op == OP_REMU);
    if (b == 0)
      ref_result = is_rem ? a : 32'hFFFFFFFF;
    else if (special_case(op, a, b))
      ref_result = is_rem ? 32'h0 : a;
    else if (op == OP_DIV)
      ref_result = $signed(a) / $signed(b);
    else if (op == OP_REM)
      ref_result = $signed(a) % $signed(b);
    else
      ref_result = is_rem ? a % b : a / b;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t: %s in case %0d, got %h, expected %h",
               $time, what, case_idx, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "result check");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout in case %0d while waiting for %s", case_idx, what);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  endtask

  //////////////////////////////////////////////////
  // one request, optionally stalled at the result
  //////////////////////////////////////////////////

  task automatic run_case(input div_op_e op, input logic [31:0] a, b, exp, input int hold);
    int cnt;
    int lat;
    cnt = 0;
    while (busy_o)
    begin
      if (cnt >= WAIT_LIMIT)
        report_timeout("busy_o to drop");
      @(negedge clk_i);
      cnt++;
    end
    req_valid_i = 1'b1;
    req_op_i    = op;
    opa_i       = a;
    opb_i       = b;
    stall_i     = (hold > 0);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    // stall kept until busy has been high for 40 cycles plus hold
    for (cnt = 1; cnt < 40 + hold && hold > 0; cnt++)
    begin
      check_value("busy_o under stall", busy_o, 1);
      check_value("res_valid_o under stall", res_valid_o, 0);
      @(negedge clk_i);
    end
    stall_i = 1'b0;
    lat = 1;
    while (!res_valid_o)
    begin
      if (lat >= WAIT_LIMIT)
        report_timeout("res_valid_o");
      @(negedge clk_i);
      lat++;
    end
    check_value("res_o", res_o, exp);
    check_value("latency", lat, (hold > 0) ? 2 : (special_case(op, a, b) ? 1 : 34));
    @(negedge clk_i);
    check_value("second res_valid_o pulse", res_valid_o, 0);
  endtask

  initial
  begin
    int          i;
    div_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rnd;
    seed        = 32'h18f8af86;
    case_idx    = 0;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = OP_DIV;
    opa_i       = '0;
    opb_i       = '0;
    stall_i     = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    for (i = 0; i < NUM_VECTORS; i++)
    begin
      case_idx = i;
      run_case(VECTORS[i].op, VECTORS[i].opa, VECTORS[i].opb, VECTORS[i].exp, 0);
    end

    for (i = 0; i < 40; i++) // random operands, divisors of varied size
    begin
      case_idx = NUM_VECTORS + i;
      rnd = $random(seed);
      op  = div_op_e'(rnd[1:0]);
      a   = $random(seed);
      rnd = $random(seed);
      b   = rnd >> ({$random(seed)} % 32);
      if (i % 8 == 7)
        b = '0;
      run_case(op, a, b, ref_result(op, a, b), 0);
    end

    for (i = 0; i < 4; i++)
    begin
      case_idx = NUM_VECTORS + 40 + i;
      op = div_op_e'(i);
      a  = $random(seed);
      b  = $random(seed);
      if (special_case(op, a, b))
        b = 32'd7;
      run_case(op, a, b, ref_result(op, a, b), 1 + ({$random(seed)} % 16));
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- verilog/div_consts.svh
// Divider constants
// word width, iteration counter width and operation code width
// shared by the package and by every divider block

`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// data word width
`define DIV_XLEN 32

// iteration counter, log2 of the word width
`define DIV_CNT_W 5

// operation code width
`define DIV_OP_W 2

`endif

//--- verilog/div_ctrl.sv
// Divider controller
// check / divide / result FSM with the iteration counter
// accepts a request only in check state, holds the result state
// while the downstream stage stalls

`timescale 1ns/1ps

`include "div_consts.svh"

module div_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_valid_i,
  input  logic special_i,
  input  logic stall_i,
  output logic start_o,
  output logic special_load_o,
  output logic step_o,
  output logic finish_o,
  output logic busy_o
);

  import div_pkg::*;

  div_state_e           state_q;
  div_state_e           state_d;
  logic [`DIV_CNT_W-1:0] cnt_q;

  // pulses decoded from the current state
  assign start_o        = (state_q == ST_CHECK) & req_valid_i & ~special_i;
  assign special_load_o = (state_q == ST_CHECK) & req_valid_i & special_i;
  assign step_o         = (state_q == ST_DIVIDE);
  assign finish_o       = (state_q == ST_RESULT) & ~stall_i;
  assign busy_o         = (state_q != ST_CHECK);

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_CHECK:  if (start_o) state_d = ST_DIVIDE; // special cases stay here
      ST_DIVIDE: if (~|cnt_q) state_d = ST_RESULT;
      ST_RESULT: if (!stall_i) state_d = ST_CHECK;
      default:   state_d = ST_CHECK;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= ST_CHECK;
      cnt_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (start_o)
        cnt_q <= {`DIV_CNT_W{1'b1}}; // one step per bit
      else if (step_o)
        cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

//--- verilog/div_operand_setup.sv
// Divider operand setup
// decodes the operation, catches divide by zero and signed overflow
// with their fixed results, and prepares magnitudes and sign flags
// for the restoring core

`timescale 1ns/1ps

`include "div_consts.svh"

module div_operand_setup (
  input  div_pkg::div_op_e      req_op_i,
  input  logic [`DIV_XLEN-1:0]  opa_i,
  input  logic [`DIV_XLEN-1:0]  opb_i,
  output logic                  special_o,
  output logic [`DIV_XLEN-1:0]  special_res_o,
  output logic [`DIV_XLEN-1:0]  dividend_o,
  output logic [`DIV_XLEN-1:0]  divisor_o,
  output logic                  neg_q_o,
  output logic                  neg_r_o
);

  import div_pkg::*;

  localparam logic [`DIV_XLEN-1:0] MOST_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};

  logic is_signed;
  logic is_rem;
  logic div_zero;
  logic overflow;
  logic sign_a;
  logic sign_b;

  // operation decode
  always_comb
  begin
    is_signed = 1'b0;
    is_rem    = 1'b0;
    case (req_op_i)
      OP_DIV:  is_signed = 1'b1;
      OP_DIVU: is_signed = 1'b0;
      OP_REM:
      begin
        is_signed = 1'b1;
        is_rem    = 1'b1;
      end
      OP_REMU: is_rem = 1'b1;
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // special cases
  //////////////////////////////////////////////////

  assign div_zero  = ~|opb_i;
  assign overflow  = is_signed & (opa_i == MOST_NEG) & (&opb_i); // -2^31 / -1
  assign special_o = div_zero | overflow;

  always_comb
  begin
    if (div_zero)
      special_res_o = is_rem ? opa_i : {`DIV_XLEN{1'b1}};
    else
      special_res_o = is_rem ? '0 : opa_i; // overflow, quotient is the dividend
  end

  //////////////////////////////////////////////////
  // magnitudes and signs
  //////////////////////////////////////////////////

  assign sign_a = is_signed & opa_i[`DIV_XLEN-1];
  assign sign_b = is_signed & opb_i[`DIV_XLEN-1];

  assign dividend_o = sign_a ? (~opa_i + 1'b1) : opa_i;
  assign divisor_o  = sign_b ? (~opb_i + 1'b1) : opb_i;

  assign neg_q_o = sign_a ^ sign_b;
  assign neg_r_o = sign_a;         // remainder follows the dividend

endmodule

//--- verilog/div_pkg.sv
// Divider package
// operation codes, controller states and the partial remainder /
// quotient word seen both as two fields and as one flat word

`include "div_consts.svh"

package div_pkg;

  //////////////////////////////////////////////////
  // operation codes
  //////////////////////////////////////////////////

  // bit 0 marks unsigned, bit 1 marks a remainder result
  typedef enum logic [`DIV_OP_W-1:0] {
    OP_DIV  = 2'd0,
    OP_DIVU = 2'd1,
    OP_REM  = 2'd2,
    OP_REMU = 2'd3
  } div_op_e;

  // controller states
  typedef enum logic [1:0] {
    ST_CHECK  = 2'd0,
    ST_DIVIDE = 2'd1,
    ST_RESULT = 2'd2
  } div_state_e;

  //////////////////////////////////////////////////
  // partial remainder and dividend / quotient
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [`DIV_XLEN-1:0] p; // partial remainder
    logic [`DIV_XLEN-1:0] a; // dividend, shifted out as quotient comes in
  } div_pa_s;

  // the step shifts the whole word at once through the flat view
  typedef union packed {
    div_pa_s                fld;
    logic [2*`DIV_XLEN-1:0] flat;
  } div_pa_u;

endpackage

//--- verilog/div_restoring_core.sv
// Restoring divider core
// holds the partial remainder / quotient word and the divisor,
// one shift-subtract-restore step per cycle while step is high

`timescale 1ns/1ps

`include "div_consts.svh"

module div_restoring_core (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  logic                  step_i,
  input  logic [`DIV_XLEN-1:0]  dividend_i,
  input  logic [`DIV_XLEN-1:0]  divisor_i,
  output div_pkg::div_pa_u      pa_o
);

  import div_pkg::*;

  div_pa_u              pa_q;
  div_pa_u              pa_shl;
  logic [`DIV_XLEN-1:0] b_q;
  logic [`DIV_XLEN:0]   p_minus_b; // msb is the borrow

  //////////////////////////////////////////////////
  // shift and trial subtract
  //////////////////////////////////////////////////

  assign pa_shl.flat = pa_q.flat << 1;
  assign p_minus_b   = {1'b0, pa_shl.fld.p} - {1'b0, b_q};

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pa_q.flat <= '0;
      b_q       <= '0;
    end
    else if (start_i)
    begin
      pa_q.fld.p <= '0;
      pa_q.fld.a <= dividend_i;
      b_q        <= divisor_i;
    end
    else if (step_i)
    begin
      if (p_minus_b[`DIV_XLEN])
      begin
        // borrow, keep the shifted remainder
        pa_q.fld.p <= pa_shl.fld.p;
        pa_q.fld.a <= {pa_shl.fld.a[`DIV_XLEN-1:1], 1'b0};
      end
      else
      begin
        pa_q.fld.p <= p_minus_b[`DIV_XLEN-1:0];
        pa_q.fld.a <= {pa_shl.fld.a[`DIV_XLEN-1:1], 1'b1}; // quotient bit set
      end
    end
  end

  assign pa_o = pa_q;

endmodule

//--- verilog/div_result_fixup.sv
// Divider result fixup
// remembers operation and sign flags of the running division,
// selects quotient or remainder, restores its sign and registers
// the result together with a one-cycle valid

`timescale 1ns/1ps

`include "div_consts.svh"

module div_result_fixup (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  logic                  special_load_i,
  input  logic                  finish_i,
  input  div_pkg::div_op_e      req_op_i,
  input  logic                  neg_q_i,
  input  logic                  neg_r_i,
  input  logic [`DIV_XLEN-1:0]  special_res_i,
  input  div_pkg::div_pa_u      pa_i,
  output logic                  res_valid_o,
  output logic [`DIV_XLEN-1:0]  res_o
);

  import div_pkg::*;

  div_op_e              op_q;
  logic                 neg_q_q;
  logic                 neg_r_q;
  logic [`DIV_XLEN-1:0] quot;
  logic [`DIV_XLEN-1:0] rem;

  // captured with the operands
  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      op_q    <= req_op_i;
      neg_q_q <= neg_q_i;
      neg_r_q <= neg_r_i;
    end
  end

  //////////////////////////////////////////////////
  // sign restore
  //////////////////////////////////////////////////

  assign quot = neg_q_q ? (~pa_i.fld.a + 1'b1) : pa_i.fld.a;
  assign rem  = neg_r_q ? (~pa_i.fld.p + 1'b1) : pa_i.fld.p;

  always_ff @(posedge clk_i)
  begin
    if (special_load_i)
      res_o <= special_res_i;
    else if (finish_i)
      res_o <= ((op_q == OP_REM) || (op_q == OP_REMU)) ? rem : quot;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      res_valid_o <= 1'b0;
    else
      res_valid_o <= special_load_i | finish_i; // single pulse per load
  end

endmodule

//--- verilog/div_top.sv
// Integer divider top level
// bit-serial restoring divider for DIV, DIVU, REM and REMU
// requests are taken only while idle, busy stays high until the
// result has left, a stall holds a finished result

`timescale 1ns/1ps

`include "div_consts.svh"

module div_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  input  div_pkg::div_op_e      req_op_i,
  input  logic [`DIV_XLEN-1:0]  opa_i,
  input  logic [`DIV_XLEN-1:0]  opb_i,
  input  logic                  stall_i,
  output logic                  busy_o,
  output logic                  res_valid_o,
  output logic [`DIV_XLEN-1:0]  res_o
);

  import div_pkg::*;

  logic                 special;
  logic [`DIV_XLEN-1:0] special_res;
  logic [`DIV_XLEN-1:0] dividend;
  logic [`DIV_XLEN-1:0] divisor;
  logic                 neg_q;
  logic                 neg_r;
  logic                 start;
  logic                 special_load;
  logic                 step;
  logic                 finish;
  div_pa_u              pa;

  div_operand_setup u_setup (
    .req_op_i      (req_op_i),
    .opa_i         (opa_i),
    .opb_i         (opb_i),
    .special_o     (special),
    .special_res_o (special_res),
    .dividend_o    (dividend),
    .divisor_o     (divisor),
    .neg_q_o       (neg_q),
    .neg_r_o       (neg_r)
  );

  div_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .special_i      (special),
    .stall_i        (stall_i),
    .start_o        (start),
    .special_load_o (special_load),
    .step_o         (step),
    .finish_o       (finish),
    .busy_o         (busy_o)
  );

  div_restoring_core u_core (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start),
    .step_i     (step),
    .dividend_i (dividend),
    .divisor_i  (divisor),
    .pa_o       (pa)
  );

  div_result_fixup u_fixup (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start),
    .special_load_i (special_load),
    .finish_i       (finish),
    .req_op_i       (req_op_i),
    .neg_q_i        (neg_q),
    .neg_r_i        (neg_r),
    .special_res_i  (special_res),
    .pa_i           (pa),
    .res_valid_o    (res_valid_o),
    .res_o          (res_o)
  );

endmodule
